// ==== rtl/sram_pkg.sv ====
package sram_pkg;

  // bank number sits in the upper address bits
  localparam int BANK_BITS = 2;

  // one external chip per bank
  localparam int NUM_BANKS = 1 << BANK_BITS;

  // address width of a single chip
  localparam int ROW_BITS = 8;

  // word width, same on every chip
  localparam int DATA_BITS = 16;

  // flat requester address
  localparam int ADDR_BITS = BANK_BITS + ROW_BITS;

  // split view of the flat address
  typedef struct packed {
    logic [BANK_BITS-1:0] bank;
    logic [ROW_BITS-1:0]  row;
  } sram_addr_split_t;

  // one address word, seen either flat or as bank plus row
  typedef union packed {
    logic [ADDR_BITS-1:0] flat;
    sram_addr_split_t     split;
  } sram_addr_u;

  // finished read held by a bank until the merger takes it
  typedef struct packed {
    logic [ROW_BITS-1:0]  row;
    logic [DATA_BITS-1:0] data;
  } rd_result_t;

endpackage

// ==== rtl/bank_req_if.sv ====
`timescale 1ns/1ps

interface bank_req_if;
  import sram_pkg::*;

  // single-cycle request strobe, no back-pressure
  logic                 strobe;
  // high for a write, low for a read
  logic                 write;
  // row inside the selected chip
  logic [ROW_BITS-1:0]  row;
  // write data, ignored on reads
  logic [DATA_BITS-1:0] wdata;
  // bank is running a chip cycle or holding a read result
  logic                 busy;

  // router side issues requests and watches busy
  modport router (
    output strobe,
    output write,
    output row,
    output wdata,
    input  busy
  );

  // sequencer side takes requests and reports busy
  modport bank (
    input  strobe,
    input  write,
    input  row,
    input  wdata,
    output busy
  );

endinterface

// ==== rtl/sram_req_router.sv ====
`timescale 1ns/1ps

module sram_req_router (
  input  logic                           oe_n,
  input  logic                           reset,
  input  logic                           req,
  input  logic                           req_write,
  input  sram_pkg::sram_addr_u           req_addr,
  input  logic [sram_pkg::DATA_BITS-1:0] req_wdata,
  bank_req_if.router                     banks [sram_pkg::NUM_BANKS],
  output logic [sram_pkg::NUM_BANKS-1:0] bank_busy
);
  import sram_pkg::*;

  // registered request, one cycle between req and bank strobe
  logic                 req_q;
  logic                 write_q;
  sram_addr_u           addr_q;
  logic [DATA_BITS-1:0] wdata_q;

  // decoded per-bank strobes
  logic [NUM_BANKS-1:0] strobe;

  // request valid, one cycle behind req
  always_ff @(posedge oe_n) begin
    if (!reset) begin
      req_q <= 1'b0;
    end else begin
      req_q <= req;
    end
  end

  // request payload, the address is stored through its flat view
  always_ff @(posedge oe_n) begin
    if (req) begin
      write_q     <= req_write;
      addr_q.flat <= req_addr.flat;
      wdata_q     <= req_wdata;
    end
  end

  // bank select comes from the split view of the stored address
  always_comb begin
    strobe = '0;
    if (req_q) begin
      strobe[addr_q.split.bank] = 1'b1;
    end
  end

  generate
    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
      // every bank sees the same payload, only one gets the strobe
      assign banks[g].strobe = strobe[g];
      assign banks[g].write  = write_q;
      assign banks[g].row    = addr_q.split.row;
      assign banks[g].wdata  = wdata_q;

      // a bank counts as busy from the strobe cycle on
      assign bank_busy[g] = banks[g].busy | strobe[g];
    end
  endgenerate

endmodule

// ==== rtl/sram_bank_seq.sv ====
`timescale 1ns/1ps

module sram_bank_seq #(
  parameter int READ_CYCLES  = 3,
  parameter int WRITE_CYCLES = 2
) (
  input  logic                           oe_n,
  input  logic                           reset,
  bank_req_if.bank                       req,
  output logic                           mem_ce_n,
  output logic                           mem_we_n,
  output logic                           mem_oe_n,
  output logic [sram_pkg::ROW_BITS-1:0]  mem_addr,
  output logic [sram_pkg::DATA_BITS-1:0] mem_dout,
  output logic                           mem_drive,
  input  logic [sram_pkg::DATA_BITS-1:0] mem_din,
  output logic                           rd_done,
  output sram_pkg::rd_result_t           rd_result,
  input  logic                           rd_taken
);
  import sram_pkg::*;

  // counter must hold the longer of the two phase lengths
  localparam int MAX_CYCLES = (READ_CYCLES > WRITE_CYCLES) ? READ_CYCLES : WRITE_CYCLES;
  localparam int CNT_BITS   = $clog2(MAX_CYCLES + 1);

  // fsm encoding
  localparam logic [2:0] ST_IDLE      = 3'd0;
  localparam logic [2:0] ST_WR_SETUP  = 3'd1;
  localparam logic [2:0] ST_WR_PULSE  = 3'd2;
  localparam logic [2:0] ST_WR_HOLD   = 3'd3;
  localparam logic [2:0] ST_RD_ACCESS = 3'd4;
  localparam logic [2:0] ST_RD_WAIT   = 3'd5;

  logic [2:0]           state;
  logic [CNT_BITS-1:0]  cnt;

  // row and data held for the whole chip cycle
  logic [ROW_BITS-1:0]  row_q;
  logic [DATA_BITS-1:0] wdata_q;
  // read word captured at the end of the access phase
  logic [DATA_BITS-1:0] rdata_q;

  // last cycle of the read access phase
  logic                 rd_last;

  assign rd_last = (state == ST_RD_ACCESS) && (cnt == '0);

  // control path
  always_ff @(posedge oe_n) begin
    if (!reset) begin
      state   <= ST_IDLE;
      cnt     <= '0;
      rd_done <= 1'b0;
    end else begin
      // rd_done is a single-cycle pulse
      rd_done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (req.strobe) begin
            if (req.write) begin
              state <= ST_WR_SETUP;
            end else begin
              state <= ST_RD_ACCESS;
              cnt   <= CNT_BITS'(READ_CYCLES - 1);
            end
          end
        end
        // chip selected, address and data settle before we_n falls
        ST_WR_SETUP: begin
          state <= ST_WR_PULSE;
          cnt   <= CNT_BITS'(WRITE_CYCLES - 1);
        end
        ST_WR_PULSE: begin
          if (cnt == '0) begin
            state <= ST_WR_HOLD;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        // the chip stores on the rising we_n, pins stay put one more cycle
        ST_WR_HOLD: begin
          state <= ST_IDLE;
        end
        ST_RD_ACCESS: begin
          if (cnt == '0) begin
            state   <= ST_RD_WAIT;
            rd_done <= 1'b1;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        // result stays on rd_result until the merger takes it
        ST_RD_WAIT: begin
          if (rd_taken) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // payload registers
  always_ff @(posedge oe_n) begin
    if (state == ST_IDLE && req.strobe) begin
      row_q   <= req.row;
      wdata_q <= req.wdata;
    end
    if (rd_last) begin
      rdata_q <= mem_din;
    end
  end

  // pin decode straight from the state register
  assign mem_ce_n  = !(state == ST_WR_SETUP || state == ST_WR_PULSE ||
                       state == ST_WR_HOLD || state == ST_RD_ACCESS);
  assign mem_we_n  = (state != ST_WR_PULSE);
  assign mem_oe_n  = (state != ST_RD_ACCESS);
  assign mem_drive = (state == ST_WR_SETUP || state == ST_WR_PULSE || state == ST_WR_HOLD);
  assign mem_addr  = row_q;
  assign mem_dout  = wdata_q;

  assign rd_result.row  = row_q;
  assign rd_result.data = rdata_q;

  // busy covers the chip cycle and the wait for the merger
  assign req.busy = (state != ST_IDLE);

  // the router must respect busy, there is no back-pressure
  a_no_strobe_busy: assert property (@(posedge oe_n) disable iff (!reset)
    req.strobe |-> !req.busy);

  // never enable chip outputs while we drive the shared bus
  a_no_bus_fight: assert property (@(posedge oe_n) disable iff (!reset)
    !mem_oe_n |-> !mem_drive);

  // address held for as long as the chip stays selected
  a_addr_stable: assert property (@(posedge oe_n) disable iff (!reset)
    (!mem_ce_n && $past(!mem_ce_n)) |-> $stable(mem_addr));

endmodule

// ==== rtl/read_merge.sv ====
`timescale 1ns/1ps

module read_merge (
  input  logic                           oe_n,
  input  logic                           reset,
  input  logic [sram_pkg::NUM_BANKS-1:0] rd_done,
  input  sram_pkg::rd_result_t           rd_result [sram_pkg::NUM_BANKS],
  output logic [sram_pkg::NUM_BANKS-1:0] rd_taken,
  output logic                           rd_valid,
  output sram_pkg::sram_addr_u           rd_addr,
  output logic [sram_pkg::DATA_BITS-1:0] rd_data
);
  import sram_pkg::*;

  // one finished read waiting per bank, word itself stays in the bank
  logic [NUM_BANKS-1:0] pending;
  // bank with first claim in the next search
  logic [BANK_BITS-1:0] ptr;

  // search state
  logic [BANK_BITS-1:0] idx;
  logic [BANK_BITS-1:0] sel;
  logic                 found;

  // round-robin search starting at ptr
  always_comb begin
    idx   = ptr;
    sel   = ptr;
    found = 1'b0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      // index wraps naturally at BANK_BITS
      idx = ptr + BANK_BITS'(i);
      if (!found && pending[idx]) begin
        sel   = idx;
        found = 1'b1;
      end
    end
  end

  // winner is returned this cycle and released in its bank
  always_comb begin
    rd_taken = '0;
    if (found) begin
      rd_taken[sel] = 1'b1;
    end
  end

  assign rd_valid = found;
  assign rd_data  = rd_result[sel].data;

  // flat address rebuilt from bank index and row
  assign rd_addr.split.bank = sel;
  assign rd_addr.split.row  = rd_result[sel].row;

  always_ff @(posedge oe_n) begin
    if (!reset) begin
      pending <= '0;
      ptr     <= '0;
    end else begin
      pending <= (pending & ~rd_taken) | rd_done;
      // the bank after the winner goes first next time
      if (found) begin
        ptr <= sel + BANK_BITS'(1);
      end
    end
  end

  // a bank stays busy until taken, so a second result cannot arrive early
  a_no_double_done: assert property (@(posedge oe_n) disable iff (!reset)
    (rd_done & pending) == '0);

endmodule

// ==== rtl/sram_ctrl_top.sv ====
`timescale 1ns/1ps

module sram_ctrl_top #(
  parameter int READ_CYCLES  = 3,
  parameter int WRITE_CYCLES = 2
) (
  input  logic                                                oe_n,
  input  logic                                                reset,
  // requester side
  input  logic                                                req,
  input  logic                                                req_write,
  input  logic [sram_pkg::ADDR_BITS-1:0]                      req_addr,
  input  logic [sram_pkg::DATA_BITS-1:0]                      req_wdata,
  output logic [sram_pkg::NUM_BANKS-1:0]                      bank_busy,
  output logic                                                rd_valid,
  output logic [sram_pkg::ADDR_BITS-1:0]                      rd_addr,
  output logic [sram_pkg::DATA_BITS-1:0]                      rd_data,
  // chip side, one entry per bank
  output logic [sram_pkg::NUM_BANKS-1:0]                      mem_ce_n,
  output logic [sram_pkg::NUM_BANKS-1:0]                      mem_we_n,
  output logic [sram_pkg::NUM_BANKS-1:0]                      mem_oe_n,
  output logic [sram_pkg::NUM_BANKS-1:0][sram_pkg::ROW_BITS-1:0]  mem_addr,
  output logic [sram_pkg::NUM_BANKS-1:0][sram_pkg::DATA_BITS-1:0] mem_dout,
  output logic [sram_pkg::NUM_BANKS-1:0]                      mem_drive,
  input  logic [sram_pkg::NUM_BANKS-1:0][sram_pkg::DATA_BITS-1:0] mem_din
);
  import sram_pkg::*;

  // router to sequencer requests
  bank_req_if bank_req [NUM_BANKS] ();

  // sequencer to merger results
  logic [NUM_BANKS-1:0] rd_done;
  rd_result_t           rd_result [NUM_BANKS];
  logic [NUM_BANKS-1:0] rd_taken;

  sram_req_router u_router (
    .oe_n      (oe_n),
    .reset     (reset),
    .req       (req),
    .req_write (req_write),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .banks     (bank_req),
    .bank_busy (bank_busy)
  );

  generate
    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
      sram_bank_seq #(
        .READ_CYCLES  (READ_CYCLES),
        .WRITE_CYCLES (WRITE_CYCLES)
      ) u_seq (
        .oe_n      (oe_n),
        .reset     (reset),
        .req       (bank_req[g]),
        .mem_ce_n  (mem_ce_n[g]),
        .mem_we_n  (mem_we_n[g]),
        .mem_oe_n  (mem_oe_n[g]),
        .mem_addr  (mem_addr[g]),
        .mem_dout  (mem_dout[g]),
        .mem_drive (mem_drive[g]),
        .mem_din   (mem_din[g]),
        .rd_done   (rd_done[g]),
        .rd_result (rd_result[g]),
        .rd_taken  (rd_taken[g])
      );
    end
  endgenerate

  // results from all banks funnel into one return port
  read_merge u_merge (
    .oe_n      (oe_n),
    .reset     (reset),
    .rd_done   (rd_done),
    .rd_result (rd_result),
    .rd_taken  (rd_taken),
    .rd_valid  (rd_valid),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

endmodule

// ==== testbench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 5
) (
  output logic oe_n,
  output logic reset
);

  // free-running clock, starts low
  initial begin
    oe_n = 1'b0;
    forever #(PERIOD / 2) oe_n = ~oe_n;
  end

  // active low reset released on a rising edge
  initial begin
    reset = 1'b0;
    repeat (RESET_CYCLES) @(posedge oe_n);
    reset <= 1'b1;
  end

endmodule

// ==== testbench/sram_chip.sv ====
`timescale 1ns/1ps

module sram_chip (
  input  logic                           oe_n,
  input  logic                           mem_ce_n,
  input  logic                           mem_we_n,
  input  logic                           mem_oe_n,
  input  logic [sram_pkg::ROW_BITS-1:0]  mem_addr,
  input  logic [sram_pkg::DATA_BITS-1:0] mem_dout,
  input  logic                           mem_drive,
  output logic [sram_pkg::DATA_BITS-1:0] mem_din,
  output logic                           err,
  output logic [31:0]                    access_cnt
);
  import sram_pkg::*;

  localparam int DEPTH = 1 << ROW_BITS;

  // storage plus a flag per row that has seen a write
  logic [DATA_BITS-1:0] mem     [DEPTH];
  logic                 written [DEPTH];

  // pins as seen on the previous edge
  logic                 ce_q;
  logic                 we_q;
  logic                 drive_q;
  logic [ROW_BITS-1:0]  addr_q;
  logic [DATA_BITS-1:0] dout_q;

  // shared data wire, the controller wins when it drives
  assign mem_din = mem_drive ? mem_dout :
                   (!mem_ce_n && !mem_oe_n) ? mem[mem_addr] : '0;

  initial begin
    err        = 1'b0;
    access_cnt = '0;
    ce_q       = 1'b1;
    we_q       = 1'b1;
    drive_q    = 1'b0;
    addr_q     = '0;
    dout_q     = '0;
    for (int i = 0; i < DEPTH; i++) begin
      written[i] = 1'b0;
    end
  end

  // print what broke and raise the error flag for the top module
  task automatic flag_violation(input string what);
    $display("sram_chip %m: %s", what);
    err <= 1'b1;
  endtask

  always @(posedge oe_n) begin
    // chip outputs and controller outputs would fight on the wire
    if (!mem_oe_n && mem_drive) begin
      flag_violation("output enable low while the controller drives the bus");
    end
    if (!mem_ce_n && !ce_q && mem_addr != addr_q) begin
      flag_violation("address changed while the chip is selected");
    end
    if (!mem_ce_n && mem_drive && drive_q && mem_dout != dout_q) begin
      flag_violation("write data changed during a write cycle");
    end
    if (!mem_ce_n && !mem_oe_n && !written[mem_addr]) begin
      flag_violation("read of a row that was never written");
    end
    // word is stored on the rising write enable
    if (!mem_ce_n && !we_q && mem_we_n) begin
      mem[mem_addr]     = mem_dout;
      written[mem_addr] = 1'b1;
    end
    // one access per falling chip enable
    if (ce_q && !mem_ce_n) begin
      access_cnt <= access_cnt + 1;
    end
    ce_q    <= mem_ce_n;
    we_q    <= mem_we_n;
    drive_q <= mem_drive;
    addr_q  <= mem_addr;
    dout_q  <= mem_dout;
  end

endmodule

// ==== testbench/tb_sram_ctrl.sv ====
`timescale 1ns/1ps

module tb_sram_ctrl;
  import sram_pkg::*;

  localparam int READ_CYCLES  = 3;
  localparam int WRITE_CYCLES = 2;
  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 5;
  // random ops, then one write burst and one read burst over all banks
  localparam int NUM_OPS      = 200;
  localparam int TOTAL_OPS    = NUM_OPS + 2 * NUM_BANKS;
  localparam int WATCHDOG_NS  =
    (TOTAL_OPS * (READ_CYCLES + NUM_BANKS + 4) + RESET_CYCLES) * CLK_PERIOD;
  // small row window so random reads keep hitting written words
  localparam logic [ROW_BITS-1:0]  ROW_MASK   = 8'h1f;
  localparam logic [NUM_BANKS-1:0] ALL_HIGH   = '1;
  localparam int                   ENTRY_BITS = ADDR_BITS + DATA_BITS;

  logic                                oe_n;
  logic                                reset;
  logic                                req;
  logic                                req_write;
  logic [ADDR_BITS-1:0]                req_addr;
  logic [DATA_BITS-1:0]                req_wdata;
  logic [NUM_BANKS-1:0]                bank_busy;
  logic                                rd_valid;
  logic [ADDR_BITS-1:0]                rd_addr;
  logic [DATA_BITS-1:0]                rd_data;
  logic [NUM_BANKS-1:0]                mem_ce_n;
  logic [NUM_BANKS-1:0]                mem_we_n;
  logic [NUM_BANKS-1:0]                mem_oe_n;
  logic [NUM_BANKS-1:0]                mem_drive;
  logic [NUM_BANKS-1:0][ROW_BITS-1:0]  mem_addr;
  logic [NUM_BANKS-1:0][DATA_BITS-1:0] mem_dout;
  wire  [NUM_BANKS-1:0][DATA_BITS-1:0] mem_din;
  wire  [NUM_BANKS-1:0]                chip_err;
  wire  [31:0]                         access_cnt [NUM_BANKS];

  // shadow memory over the flat address and expected reads per bank
  logic [DATA_BITS-1:0]  shadow  [1 << ADDR_BITS];
  bit                    written [1 << ADDR_BITS];
  logic [ENTRY_BITS-1:0] exp_q   [NUM_BANKS][$];
  int                    op_cnt  [NUM_BANKS];
  logic [ROW_BITS-1:0]   burst_row [NUM_BANKS];
  int                    ops_issued;
  integer                seed;
  // d1 was issued on the last edge, d2 on the edge before
  bit                    issued_d1;
  bit                    issued_d2;
  logic [BANK_BITS-1:0]  bank_d1;
  logic [BANK_BITS-1:0]  bank_d2;

  clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clk (
    .oe_n  (oe_n),
    .reset (reset)
  );

  sram_ctrl_top #(.READ_CYCLES(READ_CYCLES), .WRITE_CYCLES(WRITE_CYCLES)) dut0 (
    .oe_n      (oe_n),
    .reset     (reset),
    .req       (req),
    .req_write (req_write),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .bank_busy (bank_busy),
    .rd_valid  (rd_valid),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .mem_ce_n  (mem_ce_n),
    .mem_we_n  (mem_we_n),
    .mem_oe_n  (mem_oe_n),
    .mem_addr  (mem_addr),
    .mem_dout  (mem_dout),
    .mem_drive (mem_drive),
    .mem_din   (mem_din)
  );

  generate
    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_chip
      sram_chip u_chip (
        .oe_n       (oe_n),
        .mem_ce_n   (mem_ce_n[g]),
        .mem_we_n   (mem_we_n[g]),
        .mem_oe_n   (mem_oe_n[g]),
        .mem_addr   (mem_addr[g]),
        .mem_dout   (mem_dout[g]),
        .mem_drive  (mem_drive[g]),
        .mem_din    (mem_din[g]),
        .err        (chip_err[g]),
        .access_cnt (access_cnt[g])
      );
    end
  endgenerate

  task automatic abort_run(input string why);
    $display("ERROR: %s", why);
    $display("TESTS FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // banks that may take a req now, the last edge's req is not yet in bank_busy
  function automatic logic [NUM_BANKS-1:0] free_banks();
    logic [NUM_BANKS-1:0] free;
    free = ~bank_busy;
    if (issued_d2) begin
      free[bank_d2] = 1'b0;
    end
    return free;
  endfunction

  function automatic int pending_reads();
    int n;
    n = 0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      n += exp_q[b].size();
    end
    return n;
  endfunction

  // match a returned word against the queue of the bank in its address
  task automatic check_returns();
    logic [BANK_BITS-1:0]  b;
    logic [ENTRY_BITS-1:0] ent;
    if (rd_valid) begin
      b = rd_addr[ADDR_BITS-1 -: BANK_BITS];
      if (exp_q[b].size() == 0) begin
        abort_run($sformatf("read returned from bank %0d with no read outstanding", b));
      end else begin
        ent = exp_q[b].pop_front();
        check_eq("rd_addr", 32'(rd_addr), 32'(ent[ENTRY_BITS-1:DATA_BITS]));
        check_eq("rd_data", 32'(rd_data), 32'(ent[DATA_BITS-1:0]));
      end
    end
  endtask

  // wait one edge, check outputs sampled there, default req low
  task automatic next_cycle();
    @(posedge oe_n);
    if (chip_err != '0) begin
      abort_run("chip model flagged a protocol violation");
    end else begin
      check_returns();
      // req accepted one edge ago shows as busy now
      if (issued_d2) begin
        check_eq("bank_busy[bank]", 32'(bank_busy[bank_d2]), 32'd1);
      end
      issued_d2 = issued_d1;
      bank_d2   = bank_d1;
      issued_d1 = 1'b0;
      req <= 1'b0;
    end
  endtask

  task automatic issue_op(input logic [BANK_BITS-1:0] bank, input bit wr,
                          input logic [ROW_BITS-1:0] row, input logic [DATA_BITS-1:0] data);
    logic [ADDR_BITS-1:0] addr;
    addr = {bank, row};
    req       <= 1'b1;
    req_write <= wr;
    req_addr  <= addr;
    req_wdata <= data;
    // bank runs one op at a time, so the shadow value at issue is what returns
    if (wr) begin
      shadow[addr]  = data;
      written[addr] = 1'b1;
    end else begin
      exp_q[bank].push_back({addr, shadow[addr]});
    end
    op_cnt[bank]++;
    ops_issued++;
    issued_d1 = 1'b1;
    bank_d1   = bank;
  endtask

  task automatic random_step();
    logic [NUM_BANKS-1:0] free;
    logic [BANK_BITS-1:0] b;
    logic [ROW_BITS-1:0]  row;
    bit                   wr;
    free = free_banks();
    // about one idle slot in four
    if (free != '0 && ($random(seed) & 3) != 0) begin
      b = BANK_BITS'($random(seed));
      while (!free[b]) begin
        b = b + 1'b1;
      end
      row = ROW_BITS'($random(seed)) & ROW_MASK;
      // unwritten words are always written first
      wr = !written[{b, row}] || (($random(seed) & 1) != 0);
      issue_op(b, wr, row, DATA_BITS'($random(seed)));
    end
  endtask

  task automatic check_reset_state();
    check_eq("rd_valid", 32'(rd_valid), 32'd0);
    check_eq("bank_busy", 32'(bank_busy), 32'd0);
    check_eq("mem_ce_n", 32'(mem_ce_n), 32'(ALL_HIGH));
    check_eq("mem_we_n", 32'(mem_we_n), 32'(ALL_HIGH));
    check_eq("mem_oe_n", 32'(mem_oe_n), 32'(ALL_HIGH));
    check_eq("mem_drive", 32'(mem_drive), 32'd0);
  endtask

  // two edges until the last req shows in bank_busy, then wait for idle
  task automatic drain();
    next_cycle();
    next_cycle();
    while (bank_busy != '0) begin
      next_cycle();
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    abort_run($sformatf("timeout after %0d ns with %0d ops issued", WATCHDOG_NS, ops_issued));
  end

  initial begin
    seed       = 42649;
    ops_issued = 0;
    issued_d1  = 1'b0;
    issued_d2  = 1'b0;
    bank_d1    = '0;
    bank_d2    = '0;
    for (int i = 0; i < (1 << ADDR_BITS); i++) begin
      written[i] = 1'b0;
    end
    for (int b = 0; b < NUM_BANKS; b++) begin
      op_cnt[b] = 0;
    end
    req       <= 1'b0;
    req_write <= 1'b0;
    req_addr  <= '0;
    req_wdata <= '0;
    // first edge loads the reset values, check from the second on
    @(posedge oe_n);
    while (!reset) begin
      next_cycle();
      check_reset_state();
    end
    while (ops_issued < NUM_OPS) begin
      next_cycle();
      random_step();
    end
    drain();
    // back-to-back writes across all banks, then read them back the same way
    for (int i = 0; i < NUM_BANKS; i++) begin
      next_cycle();
      burst_row[i] = ROW_BITS'($random(seed));
      issue_op(BANK_BITS'(i), 1'b1, burst_row[i], DATA_BITS'($random(seed)));
    end
    drain();
    for (int i = 0; i < NUM_BANKS; i++) begin
      next_cycle();
      issue_op(BANK_BITS'(i), 1'b0, burst_row[i], '0);
    end
    drain();
    // every op touched only its own chip, once
    for (int b = 0; b < NUM_BANKS; b++) begin
      check_eq($sformatf("access_cnt[%0d]", b), access_cnt[b], 32'(op_cnt[b]));
    end
    // idle banks leave every chip deselected and the bus released
    check_eq("mem_ce_n", 32'(mem_ce_n), 32'(ALL_HIGH));
    check_eq("mem_drive", 32'(mem_drive), 32'd0);
    if (pending_reads() == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("TESTS FAILED");
      $fatal(1, "reads left outstanding at the end of the run");
    end
  end

endmodule

// ==== all.f ====
rtl/sram_pkg.sv
rtl/bank_req_if.sv
rtl/sram_req_router.sv
rtl/sram_bank_seq.sv
rtl/read_merge.sv
rtl/sram_ctrl_top.sv
testbench/clock_gen.sv
testbench/sram_chip.sv
testbench/tb_sram_ctrl.sv

// ==== Makefile ====
# Verilator build and run for the SRAM controller testbench

VERILATOR ?= verilator
TOP       ?= tb_sram_ctrl
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass message shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
